// ==== Bender.yml ====
package:
  name: dbg_host

sources:
  - hdl/dbg_proto_pkg.sv
  - hdl/dbg_target_pkg.sv
  - hdl/dbg_target_if.sv
  - hdl/dbg_rx_fifo.sv
  - hdl/dbg_rsp_serializer.sv
  - hdl/dbg_core_model.sv
  - hdl/dbg_ctrl.sv
  - hdl/dbg_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_dbg_top.sv

// ==== hdl/dbg_core_model.sv ====
`timescale 1ns/100ps

module dbg_core_model (
    input logic        clk_in,
    input logic        arst_n,
    dbg_target_if.core tgt
);

    logic [dbg_target_pkg::XLEN-1:0]       pc;
    logic [dbg_target_pkg::XLEN-1:0]       bp_addr;
    logic                                  halted;
    logic                                  bp_en;
    logic [dbg_target_pkg::XLEN-1:0]       regs [dbg_target_pkg::REG_COUNT];
    logic [dbg_target_pkg::XLEN-1:0]       imem [dbg_target_pkg::IMEM_WORDS];
    logic [dbg_target_pkg::REG_IDX_W-1:0]  reg_idx;
    logic [dbg_target_pkg::IMEM_IDX_W-1:0] imem_idx;
    logic                                  bp_hit;
    logic                                  do_reset;

    assign reg_idx  = tgt.addr[dbg_target_pkg::REG_IDX_W-1:0];
    assign imem_idx = tgt.addr[dbg_target_pkg::IMEM_IDX_W+1:2];   // Word aligned
    assign bp_hit   = bp_en && (pc == bp_addr);
    assign do_reset = tgt.req_valid && (tgt.op == dbg_target_pkg::TGT_RESET);

    // Run and halt control
    always_ff @(posedge clk_in or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc      <= dbg_target_pkg::PC_INITIAL;
            halted  <= 1'b1;
            bp_en   <= 1'b0;
            bp_addr <= '0;
        end
        else
        begin
            if (!halted)
            begin
                if (bp_hit)
                    halted <= 1'b1;         // Stop with pc on the breakpoint
                else
                    pc <= pc + dbg_target_pkg::PC_STEP;
            end

            // Requests take priority over the run step
            if (tgt.req_valid)
            begin
                case (tgt.op)
                    dbg_target_pkg::TGT_RUN:    halted  <= 1'b0;
                    dbg_target_pkg::TGT_EN_BP:  bp_en   <= 1'b1;
                    dbg_target_pkg::TGT_DIS_BP: bp_en   <= 1'b0;
                    dbg_target_pkg::TGT_SET_BP: bp_addr <= tgt.addr;
                    dbg_target_pkg::TGT_RESET:
                    begin
                        pc     <= dbg_target_pkg::PC_INITIAL;
                        halted <= 1'b1;
                        bp_en  <= 1'b0;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Register file, instruction memory and read port
    always_ff @(posedge clk_in)
    begin
        if (tgt.req_valid)
        begin
            case (tgt.op)
                dbg_target_pkg::TGT_WR_REG:    regs[reg_idx]   <= tgt.wdata;
                dbg_target_pkg::TGT_WR_IMEM:   imem[imem_idx]  <= tgt.wdata;
                dbg_target_pkg::TGT_RD_REG:    tgt.rdata       <= regs[reg_idx];
                dbg_target_pkg::TGT_RD_IMEM:   tgt.rdata       <= imem[imem_idx];
                dbg_target_pkg::TGT_RD_PC:     tgt.rdata       <= pc;
                dbg_target_pkg::TGT_RD_STATUS:
                    tgt.rdata <= {{(dbg_target_pkg::XLEN-1){1'b0}}, halted};
                default: ;
            endcase
        end
    end

    a_pc_frozen: assert property (@(posedge clk_in) disable iff (!arst_n)
        halted && !do_reset |=> $stable(pc))
        else $error("pc changed while the core was halted");

endmodule

// ==== hdl/dbg_ctrl.sv ====
`timescale 1ns/100ps

module dbg_ctrl (
    input  logic                            clk_in,
    input  logic                            arst_n,
    input  logic [7:0]                      head,
    input  logic                            empty,
    output logic                            pop,
    dbg_target_if.ctrl                      tgt,
    output logic                            rsp_valid,
    output dbg_proto_pkg::dbg_rsp_e         rsp_kind,
    output logic [dbg_target_pkg::XLEN-1:0] rsp_word,
    input  logic                            rsp_busy
);

    dbg_proto_pkg::dbg_ctrl_state_e  state;
    dbg_proto_pkg::dbg_ctrl_state_e  exec_state;
    dbg_target_pkg::dbg_tgt_op_e     op_q;
    dbg_target_pkg::dbg_tgt_op_e     op_dec;
    logic [7:0]                      cmd;
    logic [1:0]                      byte_cnt;
    logic [dbg_target_pkg::XLEN-1:0] word1;
    logic [dbg_target_pkg::XLEN-1:0] word2;

    // Opcode byte to target operation
    always_comb
    begin
        case (head)
            dbg_proto_pkg::CMD_STATUS:     op_dec = dbg_target_pkg::TGT_RD_STATUS;
            dbg_proto_pkg::CMD_CONT:       op_dec = dbg_target_pkg::TGT_RUN;
            dbg_proto_pkg::CMD_EN_BP:      op_dec = dbg_target_pkg::TGT_EN_BP;
            dbg_proto_pkg::CMD_DIS_BP:     op_dec = dbg_target_pkg::TGT_DIS_BP;
            dbg_proto_pkg::CMD_READ_PC:    op_dec = dbg_target_pkg::TGT_RD_PC;
            dbg_proto_pkg::CMD_RESET:      op_dec = dbg_target_pkg::TGT_RESET;
            dbg_proto_pkg::CMD_SET_BP:     op_dec = dbg_target_pkg::TGT_SET_BP;
            dbg_proto_pkg::CMD_READ_REG:   op_dec = dbg_target_pkg::TGT_RD_REG;
            dbg_proto_pkg::CMD_READ_IMEM:  op_dec = dbg_target_pkg::TGT_RD_IMEM;
            dbg_proto_pkg::CMD_WRITE_REG:  op_dec = dbg_target_pkg::TGT_WR_REG;
            dbg_proto_pkg::CMD_WRITE_IMEM: op_dec = dbg_target_pkg::TGT_WR_IMEM;
            default:                       op_dec = dbg_target_pkg::TGT_NONE;
        endcase
    end

    // Unknown opcodes still consume their words, then skip the core
    assign exec_state = (op_q == dbg_target_pkg::TGT_NONE) ?
                        dbg_proto_pkg::ST_RESPOND : dbg_proto_pkg::ST_ISSUE;

    assign pop = !empty && (state == dbg_proto_pkg::ST_IDLE  ||
                            state == dbg_proto_pkg::ST_WORD1 ||
                            state == dbg_proto_pkg::ST_WORD2);

    always_ff @(posedge clk_in or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= dbg_proto_pkg::ST_IDLE;
            op_q     <= dbg_target_pkg::TGT_NONE;
            cmd      <= '0;
            byte_cnt <= '0;
        end
        else
        begin
            case (state)
                dbg_proto_pkg::ST_IDLE:
                    if (pop)
                    begin
                        cmd      <= head;
                        op_q     <= op_dec;
                        byte_cnt <= '0;
                        if (head[7])
                            state <= dbg_proto_pkg::ST_WORD1;
                        else if (op_dec == dbg_target_pkg::TGT_NONE)
                            state <= dbg_proto_pkg::ST_RESPOND;
                        else
                            state <= dbg_proto_pkg::ST_ISSUE;
                    end
                dbg_proto_pkg::ST_WORD1:
                    if (pop)
                    begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3)
                            state <= cmd[6] ? dbg_proto_pkg::ST_WORD2 : exec_state;
                    end
                dbg_proto_pkg::ST_WORD2:
                    if (pop)
                    begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3)
                            state <= exec_state;
                    end
                dbg_proto_pkg::ST_ISSUE:     state <= dbg_proto_pkg::ST_WAIT_DATA;
                dbg_proto_pkg::ST_WAIT_DATA:
                    state <= rsp_busy ? dbg_proto_pkg::ST_RESPOND : dbg_proto_pkg::ST_IDLE;
                dbg_proto_pkg::ST_RESPOND:
                    if (!rsp_busy)
                        state <= dbg_proto_pkg::ST_IDLE;
                default:                     state <= dbg_proto_pkg::ST_IDLE;
            endcase
        end
    end

    // Little-endian word assembly
    always_ff @(posedge clk_in)
    begin
        if (pop && state == dbg_proto_pkg::ST_WORD1)
            word1[{byte_cnt, 3'b000} +: 8] <= head;
        if (pop && state == dbg_proto_pkg::ST_WORD2)
            word2[{byte_cnt, 3'b000} +: 8] <= head;
    end

    assign tgt.req_valid = (state == dbg_proto_pkg::ST_ISSUE);
    assign tgt.op        = op_q;
    assign tgt.addr      = word1;
    assign tgt.wdata     = word2;

    // rdata holds until the next request, so it can feed the response directly
    assign rsp_valid = !rsp_busy && (state == dbg_proto_pkg::ST_WAIT_DATA ||
                                     state == dbg_proto_pkg::ST_RESPOND);

    always_comb
    begin
        case (op_q)
            dbg_target_pkg::TGT_RD_REG,
            dbg_target_pkg::TGT_RD_IMEM,
            dbg_target_pkg::TGT_RD_PC:
            begin
                rsp_kind = dbg_proto_pkg::RSP_WORD;
                rsp_word = tgt.rdata;
            end
            // Status comes back as one byte, 01h when halted
            dbg_target_pkg::TGT_RD_STATUS:
            begin
                rsp_kind = dbg_proto_pkg::RSP_ACK;
                rsp_word = tgt.rdata;
            end
            dbg_target_pkg::TGT_NONE:
            begin
                rsp_kind = dbg_proto_pkg::RSP_ACK;
                rsp_word = {{(dbg_target_pkg::XLEN-8){1'b0}}, dbg_proto_pkg::ACK_UNKNOWN};
            end
            default:
            begin
                rsp_kind = dbg_proto_pkg::RSP_ACK;     // Echo the opcode
                rsp_word = {{(dbg_target_pkg::XLEN-8){1'b0}}, cmd};
            end
        endcase
    end

endmodule

// ==== hdl/dbg_proto_pkg.sv ====
package dbg_proto_pkg;

    // Host opcodes. Bit 7 means one word follows, bit 6 a second word
    typedef enum logic [7:0] {
        CMD_STATUS     = 8'h01,
        CMD_CONT       = 8'h02,
        CMD_EN_BP      = 8'h03,
        CMD_DIS_BP     = 8'h04,
        CMD_READ_PC    = 8'h0A,
        CMD_RESET      = 8'h0B,
        CMD_SET_BP     = 8'h85,
        CMD_READ_REG   = 8'h86,
        CMD_READ_IMEM  = 8'h8C,
        CMD_WRITE_REG  = 8'hC7,
        CMD_WRITE_IMEM = 8'hCD
    } dbg_cmd_e;

    // Receive side, sender owns RX_DEPTH credits after reset
    localparam int RX_DEPTH = 4;                 // Power of two so pointers wrap
    localparam int RX_PTR_W = $clog2(RX_DEPTH);

    // Transmit side credit counter
    localparam int TX_CNT_W = 3;
    localparam logic [TX_CNT_W-1:0] TX_CREDITS = 3'd4;

    // Byte returned for an opcode that is not decoded
    localparam logic [7:0] ACK_UNKNOWN = 8'hFF;

    typedef enum logic {
        RSP_ACK,                                 // One byte
        RSP_WORD                                 // Four bytes, LSB first
    } dbg_rsp_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WORD1,
        ST_WORD2,
        ST_ISSUE,
        ST_WAIT_DATA,
        ST_RESPOND
    } dbg_ctrl_state_e;

endpackage

// ==== hdl/dbg_rsp_serializer.sv ====
`timescale 1ns/100ps

module dbg_rsp_serializer (
    input  logic                    clk_in,
    input  logic                    arst_n,
    input  logic                    rsp_valid,
    input  dbg_proto_pkg::dbg_rsp_e rsp_kind,
    input  logic [31:0]             rsp_word,
    output logic                    busy,
    output logic                    tx_valid,
    output logic [7:0]              tx_data,
    input  logic                    tx_credit
);

    logic                               active;
    logic [1:0]                         bytes_left;   // Bytes after the current one
    logic [31:0]                        shreg;
    logic [dbg_proto_pkg::TX_CNT_W-1:0] credits;
    logic                               load;

    assign busy     = active;
    assign load     = rsp_valid && !active;
    assign tx_valid = active && (credits != '0);
    assign tx_data  = shreg[7:0];

    always_ff @(posedge clk_in or negedge arst_n)
    begin
        if (!arst_n)
        begin
            active     <= 1'b0;
            bytes_left <= '0;
            credits    <= dbg_proto_pkg::TX_CREDITS;
        end
        else
        begin
            if (load)
            begin
                active     <= 1'b1;
                bytes_left <= (rsp_kind == dbg_proto_pkg::RSP_WORD) ? 2'd3 : 2'd0;
            end
            else if (tx_valid)
            begin
                if (bytes_left == 2'd0)
                    active <= 1'b0;          // Last byte out
                else
                    bytes_left <= bytes_left - 1'b1;
            end

            case ({tx_valid, tx_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (load)
            shreg <= rsp_word;
        else if (tx_valid)
            shreg <= {8'h00, shreg[31:8]};   // Low byte first
    end

    // Receiver returns no more credits than it was given
    a_credit_cap: assert property (@(posedge clk_in) disable iff (!arst_n)
        tx_credit && !tx_valid |-> credits != dbg_proto_pkg::TX_CREDITS)
        else $error("tx credit counter overflow");

endmodule

// ==== hdl/dbg_rx_fifo.sv ====
`timescale 1ns/100ps

module dbg_rx_fifo (
    input  logic       clk_in,
    input  logic       arst_n,
    input  logic       wr_valid,
    input  logic [7:0] wr_data,
    input  logic       pop,
    output logic [7:0] head,
    output logic       empty,
    output logic       credit
);

    logic [7:0]                        mem [dbg_proto_pkg::RX_DEPTH];
    logic [dbg_proto_pkg::RX_PTR_W-1:0] wr_ptr;
    logic [dbg_proto_pkg::RX_PTR_W-1:0] rd_ptr;
    logic [dbg_proto_pkg::RX_PTR_W:0]   count;
    logic                              full;

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == dbg_proto_pkg::RX_DEPTH);

    always_ff @(posedge clk_in or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end
        else
        begin
            if (wr_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;

            case ({wr_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            credit <= pop;       // One credit back per byte consumed
        end
    end

    // Storage only
    always_ff @(posedge clk_in)
    begin
        if (wr_valid)
            mem[wr_ptr] <= wr_data;
    end

    // The sender may only write while it holds a credit, so a full FIFO
    // sees no write
    a_no_overrun: assert property (@(posedge clk_in) disable iff (!arst_n)
        wr_valid |-> !full)
        else $error("rx byte arrived with the FIFO full");

endmodule

// ==== hdl/dbg_target_if.sv ====
`timescale 1ns/100ps

// Request channel from the debug controller to the target core
interface dbg_target_if;

    logic                              req_valid;   // Single cycle strobe
    dbg_target_pkg::dbg_tgt_op_e       op;
    logic [dbg_target_pkg::XLEN-1:0]   addr;        // First command word
    logic [dbg_target_pkg::XLEN-1:0]   wdata;       // Second command word
    logic [dbg_target_pkg::XLEN-1:0]   rdata;       // Valid the cycle after req_valid

    modport ctrl (
        output req_valid,
        output op,
        output addr,
        output wdata,
        input  rdata
    );

    modport core (
        input  req_valid,
        input  op,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// ==== hdl/dbg_target_pkg.sv ====
package dbg_target_pkg;

    localparam int XLEN       = 32;
    localparam int REG_COUNT  = 32;
    localparam int REG_IDX_W  = $clog2(REG_COUNT);
    localparam int IMEM_WORDS = 256;
    localparam int IMEM_IDX_W = $clog2(IMEM_WORDS);   // Taken from addr[9:2]

    localparam logic [XLEN-1:0] PC_INITIAL = 32'h8000_0000;
    localparam logic [XLEN-1:0] PC_STEP    = 32'd4;

    typedef enum logic [3:0] {
        TGT_NONE,
        TGT_RUN,
        TGT_EN_BP,
        TGT_DIS_BP,
        TGT_SET_BP,
        TGT_RD_REG,
        TGT_WR_REG,
        TGT_RD_IMEM,
        TGT_WR_IMEM,
        TGT_RD_PC,
        TGT_RD_STATUS,
        TGT_RESET
    } dbg_tgt_op_e;

endpackage

// ==== hdl/dbg_top.sv ====
`timescale 1ns/100ps

module dbg_top (
    input  logic       clk_in,
    input  logic       arst_n,
    input  logic       rx_valid,
    input  logic [7:0] rx_data,
    output logic       rx_credit,
    output logic       tx_valid,
    output logic [7:0] tx_data,
    input  logic       tx_credit
);

    logic [7:0]                      rx_head;
    logic                            rx_empty;
    logic                            rx_pop;
    logic                            rsp_valid;
    dbg_proto_pkg::dbg_rsp_e         rsp_kind;
    logic [dbg_target_pkg::XLEN-1:0] rsp_word;
    logic                            rsp_busy;

    dbg_target_if tgt_if ();

    dbg_rx_fifo rx_fifo_i (
        .clk_in   (clk_in),
        .arst_n   (arst_n),
        .wr_valid (rx_valid),
        .wr_data  (rx_data),
        .pop      (rx_pop),
        .head     (rx_head),
        .empty    (rx_empty),
        .credit   (rx_credit)
    );

    dbg_ctrl ctrl_i (
        .clk_in    (clk_in),
        .arst_n    (arst_n),
        .head      (rx_head),
        .empty     (rx_empty),
        .pop       (rx_pop),
        .tgt       (tgt_if.ctrl),
        .rsp_valid (rsp_valid),
        .rsp_kind  (rsp_kind),
        .rsp_word  (rsp_word),
        .rsp_busy  (rsp_busy)
    );

    dbg_core_model core_i (
        .clk_in (clk_in),
        .arst_n (arst_n),
        .tgt    (tgt_if.core)
    );

    dbg_rsp_serializer ser_i (
        .clk_in    (clk_in),
        .arst_n    (arst_n),
        .rsp_valid (rsp_valid),
        .rsp_kind  (rsp_kind),
        .rsp_word  (rsp_word),
        .busy      (rsp_busy),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_credit (tx_credit)
    );

endmodule

// ==== src.f ====
hdl/dbg_proto_pkg.sv
hdl/dbg_target_pkg.sv
hdl/dbg_target_if.sv
hdl/dbg_rx_fifo.sv
hdl/dbg_rsp_serializer.sv
hdl/dbg_core_model.sv
hdl/dbg_ctrl.sv
hdl/dbg_top.sv
tb/tb_clk_gen.sv
tb/tb_dbg_top.sv

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_in,
    output logic arst_n
);

    localparam int HALF_PERIOD  = 20;   // 40 ns clock
    localparam int RESET_CYCLES = 10;

    initial
    begin
        clk_in = 1'b0;
        forever #(HALF_PERIOD) clk_in = ~clk_in;
    end

    initial
    begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_in);
        @(negedge clk_in);
        arst_n = 1'b1;                  // Released away from the active edge
    end

endmodule

// ==== tb/tb_dbg_top.sv ====
`timescale 1ns/100ps

module tb_dbg_top;

    localparam int MAX_CMDS       = 200;
    localparam int CYCLES_PER_CMD = 40;
    localparam int TIMEOUT_CYCLES = MAX_CMDS * CYCLES_PER_CMD;
    localparam int HOLD_CYCLES    = 30;
    localparam int BURST_CMDS     = 8;

    typedef struct packed {
        logic [1:0] delay;              // Cycles before the credit goes back
        logic       capture;            // Keep the byte instead of comparing
        logic [7:0] data;
    } exp_byte_t;

    logic       clk_in;
    logic       arst_n;
    logic       rx_valid;
    logic [7:0] rx_data;
    logic       rx_credit;
    logic       tx_valid;
    logic [7:0] tx_data;
    logic       tx_credit;

    logic [7:0] send_q [$];             // Bytes still to go to the DUT
    exp_byte_t  exp_q [$];
    logic [7:0] cap_q [$];
    int         credit_due [$];         // Cycle at which each tx credit returns
    int         cycle;
    int         rx_credits;
    int         held_bytes;
    bit         hold_credits;

    // Reference model of the target
    logic [31:0] model_regs [dbg_target_pkg::REG_COUNT];
    logic [31:0] model_imem [dbg_target_pkg::IMEM_WORDS];
    bit          reg_known [dbg_target_pkg::REG_COUNT];
    bit          imem_known [dbg_target_pkg::IMEM_WORDS];
    int          reg_list [$];
    int          imem_list [$];
    logic [31:0] model_pc;
    logic [31:0] model_bp_addr;
    logic        model_bp_en;

    tb_clk_gen clk_gen_i (
        .clk_in (clk_in),
        .arst_n (arst_n)
    );

    dbg_top dut_i (
        .clk_in    (clk_in),
        .arst_n    (arst_n),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_credit (rx_credit),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_credit (tx_credit)
    );

    task automatic stop_on_failure();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic drive_rx_byte();
        rx_valid = 1'b1;
        rx_data  = send_q.pop_front();
        rx_credits--;
    endtask

    task automatic take_tx_byte();
        exp_byte_t e;
        if (hold_credits)
            held_bytes++;
        assert (exp_q.size() != 0)
        else
        begin
            $display("Unexpected byte 0x%02h on tx_data with no response pending", tx_data);
            stop_on_failure();
        end
        e = exp_q.pop_front();
        credit_due.push_back(cycle + 1 + e.delay);
        if (e.capture)
            cap_q.push_back(tx_data);
        else
        begin
            assert (tx_data === e.data)
            else
            begin
                $display("Error: tx_data expected 0x%02h actual 0x%02h", e.data, tx_data);
                stop_on_failure();
            end
        end
    endtask

    // Both links are driven and sampled on the falling edge
    always @(negedge clk_in)
    begin
        cycle++;
        if (cycle > TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_failure();
        end
        if (rx_credit)
            rx_credits++;
        assert (rx_credits <= dbg_proto_pkg::RX_DEPTH)
        else
        begin
            $display("The DUT returned more rx credits than it was given");
            stop_on_failure();
        end
        if (send_q.size() != 0 && rx_credits != 0)
            drive_rx_byte();
        else
            rx_valid = 1'b0;
        if (tx_valid)
            take_tx_byte();
        if (!hold_credits && credit_due.size() != 0 && credit_due[0] <= cycle)
        begin
            tx_credit = 1'b1;
            void'(credit_due.pop_front());
        end
        else
            tx_credit = 1'b0;
    end

    task automatic queue_expected(input logic [7:0] b, input bit capture);
        exp_byte_t e;
        e.delay   = $urandom_range(3, 0);
        e.capture = capture;
        e.data    = b;
        exp_q.push_back(e);
    endtask

    task automatic push_word(input logic [31:0] w);
        for (int i = 0; i < 4; i++)
            send_q.push_back(w[8*i +: 8]);      // Little endian
    endtask

    task automatic expect_word(input logic [31:0] w);
        for (int i = 0; i < 4; i++)
            queue_expected(w[8*i +: 8], 1'b0);
    endtask

    task automatic wait_idle();
        while (send_q.size() != 0 || exp_q.size() != 0)
            @(posedge clk_in);
    endtask

    task automatic send_simple(input logic [7:0] op);
        send_q.push_back(op);
        queue_expected(op, 1'b0);               // ACK echoes the opcode
    endtask

    task automatic expect_status(input logic [7:0] s);
        send_q.push_back(dbg_proto_pkg::CMD_STATUS);
        queue_expected(s, 1'b0);
    endtask

    task automatic poll_status(output logic [7:0] s);
        send_q.push_back(dbg_proto_pkg::CMD_STATUS);
        queue_expected(8'h00, 1'b1);
        wait_idle();
        s = cap_q.pop_front();
    endtask

    task automatic read_pc();
        send_q.push_back(dbg_proto_pkg::CMD_READ_PC);
        expect_word(model_pc);
    endtask

    task automatic set_bp(input logic [31:0] addr);
        send_q.push_back(dbg_proto_pkg::CMD_SET_BP);
        push_word(addr);
        queue_expected(dbg_proto_pkg::CMD_SET_BP, 1'b0);
        model_bp_addr = addr;
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        int idx;
        idx = addr[4:0];                        // Register index from the low bits
        send_q.push_back(dbg_proto_pkg::CMD_WRITE_REG);
        push_word(addr);
        push_word(data);
        queue_expected(dbg_proto_pkg::CMD_WRITE_REG, 1'b0);
        model_regs[idx] = data;
        if (!reg_known[idx])
        begin
            reg_known[idx] = 1'b1;
            reg_list.push_back(idx);
        end
    endtask

    task automatic read_reg(input int idx);
        logic [31:0] addr;
        addr = ($urandom() & 32'hFFFF_FFE0) | idx;   // Upper bits are ignored
        send_q.push_back(dbg_proto_pkg::CMD_READ_REG);
        push_word(addr);
        expect_word(model_regs[idx]);
    endtask

    task automatic write_imem(input int idx, input logic [31:0] data);
        send_q.push_back(dbg_proto_pkg::CMD_WRITE_IMEM);
        push_word(idx * 4);
        push_word(data);
        queue_expected(dbg_proto_pkg::CMD_WRITE_IMEM, 1'b0);
        model_imem[idx] = data;
        if (!imem_known[idx])
        begin
            imem_known[idx] = 1'b1;
            imem_list.push_back(idx);
        end
    endtask

    task automatic read_imem(input int idx);
        send_q.push_back(dbg_proto_pkg::CMD_READ_IMEM);
        push_word(idx * 4);
        expect_word(model_imem[idx]);
    endtask

    function automatic bit is_known(input logic [7:0] op);
        case (op)
            8'h01, 8'h02, 8'h03, 8'h04, 8'h0A, 8'h0B,
            8'h85, 8'h86, 8'h8C, 8'hC7, 8'hCD: return 1'b1;
            default:                          return 1'b0;
        endcase
    endfunction

    task automatic send_unknown();
        logic [7:0] op;
        do
        begin
            op = $urandom_range(255, 0);
        end
        while (is_known(op) || op[7:6] == 2'b01);
        send_q.push_back(op);
        if (op[7])
            push_word($urandom());
        if (op[7] && op[6])
            push_word($urandom());
        queue_expected(8'hFF, 1'b0);
    endtask

    initial
    begin
        logic [7:0] status;
        int         polls;
        rx_valid      = 1'b0;
        rx_data       = 8'h00;
        tx_credit     = 1'b0;
        rx_credits    = dbg_proto_pkg::RX_DEPTH;
        cycle         = 0;
        held_bytes    = 0;
        hold_credits  = 1'b0;
        model_pc      = dbg_target_pkg::PC_INITIAL;
        model_bp_addr = '0;
        model_bp_en   = 1'b0;
        void'($urandom(32'h1e40));
        @(posedge arst_n);
        @(posedge clk_in);

        // Reset state
        read_pc();
        expect_status(8'h01);
        wait_idle();

        for (int i = 0; i < 50; i++)
        begin
            if (reg_list.size() == 0 || $urandom_range(1, 0) == 0)
                write_reg($urandom(), $urandom());
            else
                read_reg(reg_list[$urandom_range(reg_list.size() - 1, 0)]);
        end
        wait_idle();

        for (int i = 0; i < 50; i++)
        begin
            if (imem_list.size() == 0 || $urandom_range(1, 0) == 0)
                write_imem($urandom_range(dbg_target_pkg::IMEM_WORDS - 1, 0), $urandom());
            else
                read_imem(imem_list[$urandom_range(imem_list.size() - 1, 0)]);
        end
        wait_idle();

        // Run to a breakpoint a few dozen steps ahead
        set_bp(dbg_target_pkg::PC_INITIAL + 4 * $urandom_range(60, 1));
        send_simple(dbg_proto_pkg::CMD_EN_BP);
        model_bp_en = 1'b1;
        send_simple(dbg_proto_pkg::CMD_CONT);
        wait_idle();
        polls  = 0;
        status = 8'h00;
        while (status != 8'h01 && polls < 40)
        begin
            poll_status(status);
            polls++;
            assert (status == 8'h00 || status == 8'h01)
            else
            begin
                $display("Error: tx_data status expected 0x00 or 0x01 actual 0x%02h", status);
                stop_on_failure();
            end
        end
        assert (status == 8'h01)
        else
        begin
            $display("The core did not halt at the breakpoint");
            stop_on_failure();
        end
        model_pc = model_bp_addr;
        read_pc();
        send_simple(dbg_proto_pkg::CMD_DIS_BP);
        model_bp_en = 1'b0;
        send_simple(dbg_proto_pkg::CMD_CONT);
        // Sitting on the breakpoint, so it halts at once only while enabled
        expect_status(model_bp_en ? 8'h01 : 8'h00);
        send_simple(dbg_proto_pkg::CMD_RESET);
        model_pc = dbg_target_pkg::PC_INITIAL;
        read_pc();
        expect_status(8'h01);
        wait_idle();

        // Back-pressure burst with tx credits withheld
        while (credit_due.size() != 0)
            @(posedge clk_in);
        held_bytes   = 0;
        hold_credits = 1'b1;
        for (int i = 0; i < BURST_CMDS; i++)
            read_reg(reg_list[$urandom_range(reg_list.size() - 1, 0)]);
        repeat (HOLD_CYCLES) @(posedge clk_in);
        assert (held_bytes <= dbg_proto_pkg::TX_CREDITS)
        else
        begin
            $display("The DUT sent %0d bytes with only %0d credits", held_bytes,
                     dbg_proto_pkg::TX_CREDITS);
            stop_on_failure();
        end
        assert (send_q.size() != 0)
        else
        begin
            $display("Withheld tx credits did not stall the command sender");
            stop_on_failure();
        end
        hold_credits = 1'b0;
        wait_idle();

        // Unknown opcodes leave the target untouched
        for (int i = 0; i < 10; i++)
            send_unknown();
        for (int i = 0; i < 4; i++)
        begin
            read_reg(reg_list[$urandom_range(reg_list.size() - 1, 0)]);
            read_imem(imem_list[$urandom_range(imem_list.size() - 1, 0)]);
        end
        read_pc();
        expect_status(8'h01);
        wait_idle();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
